// File: verilog/snoop_pkg.sv
package snoop_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int NUM_CORES       = 2;
  localparam int PC_WIDTH        = 64;
  localparam int LITE_ADDR_WIDTH = 32;
  localparam int LITE_DATA_WIDTH = 32;
  localparam int FIFO_DEPTH      = 8;
  localparam int PTR_WIDTH       = $clog2(FIFO_DEPTH);
  localparam int CNT_WIDTH       = 4;
  localparam int LANE_CNT_WIDTH  = 16;

  // ------------------------------
  // Register map, byte offsets
  // ------------------------------
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_CTRL      = 32'h00;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_PRIV_MASK = 32'h04;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_WATERMARK = 32'h08;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_TRIG_LO   = 32'h0C;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_TRIG_HI   = 32'h10;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_STATUS    = 32'h14;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_LANE0_CNT = 32'h18;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_LANE1_CNT = 32'h1C;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_HEAD_BASE = 32'h20;
  localparam logic [LITE_ADDR_WIDTH-1:0] REG_POP       = 32'h3C;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // Raw branch trace from one core
  typedef struct packed {
    logic                v;
    logic [1:0]          priv;
    logic [PC_WIDTH-1:0] src_pc;
    logic [PC_WIDTH-1:0] dst_pc;
    logic [3:0]          ctr_type;
    logic [31:0]         instr;
  } core_trace_t;

  // One record in snooper word format, head word order
  typedef struct packed {
    logic [LITE_DATA_WIDTH-1:0] pc_src_h;
    logic [LITE_DATA_WIDTH-1:0] pc_src_l;
    logic [LITE_DATA_WIDTH-1:0] pc_dst_h;
    logic [LITE_DATA_WIDTH-1:0] pc_dst_l;
    logic [LITE_DATA_WIDTH-1:0] metadata;
    logic [LITE_DATA_WIDTH-1:0] opcode;
    logic [LITE_DATA_WIDTH-1:0] priv_lvl;
  } trace_word_t;

  typedef struct packed {
    logic                enable;
    logic                core_select;
    logic [3:0]          priv_mask;
    logic [3:0]          watermark;
    logic [PC_WIDTH-1:0] trig_addr;
  } snoop_cfg_t;

  typedef struct packed {
    logic [CNT_WIDTH-1:0]                          occupancy;
    logic                                          overflow;
    logic                                          trigger;
    logic [NUM_CORES-1:0][LANE_CNT_WIDTH-1:0]      lane_count;
  } snoop_status_t;

  typedef struct packed {
    logic                         awvalid;
    logic [LITE_ADDR_WIDTH-1:0]   awaddr;
    logic                         wvalid;
    logic [LITE_DATA_WIDTH-1:0]   wdata;
    logic [LITE_DATA_WIDTH/8-1:0] wstrb;
    logic                         bready;
    logic                         arvalid;
    logic [LITE_ADDR_WIDTH-1:0]   araddr;
    logic                         rready;
  } lite_req_t;

  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    logic [1:0]                 bresp;
    logic                       arready;
    logic                       rvalid;
    logic [LITE_DATA_WIDTH-1:0] rdata;
    logic [1:0]                 rresp;
  } lite_rsp_t;

endpackage

// File: verilog/trace_lane.sv
module trace_lane (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  snoop_pkg::core_trace_t               trace_i,
  input  logic [3:0]                           priv_mask_i,
  output snoop_pkg::trace_word_t               rec_o,
  output logic                                 rec_valid_o,
  output logic [snoop_pkg::LANE_CNT_WIDTH-1:0] count_o
);

  logic                   accept;
  snoop_pkg::trace_word_t packed_rec;

  // One mask bit per privilege level
  assign accept = trace_i.v && priv_mask_i[trace_i.priv];

  // ------------------------------
  // Record packing
  // ------------------------------
  always_comb begin
    // High words carry PC bits 62..32, top bit zero
    packed_rec.pc_src_h = {1'b0, trace_i.src_pc[62:32]};
    packed_rec.pc_dst_h = {1'b0, trace_i.dst_pc[62:32]};
    // Low words drop PC bit 0
    packed_rec.pc_src_l = {trace_i.src_pc[31:1], 1'b0};
    packed_rec.pc_dst_l = {trace_i.dst_pc[31:1], 1'b0};
    packed_rec.metadata = {28'b0, trace_i.ctr_type};
    packed_rec.opcode   = trace_i.instr;
    packed_rec.priv_lvl = {30'b0, trace_i.priv};
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_o <= packed_rec;
    end
  end

  // Valid flag and accepted-record count, count wraps
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_valid_o <= 1'b0;
      count_o     <= '0;
    end else begin
      rec_valid_o <= accept;
      if (accept) begin
        count_o <= count_o + 1'b1;
      end
    end
  end

endmodule

// File: verilog/trace_fifo.sv
module trace_fifo (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            push_i,
  input  snoop_pkg::trace_word_t          push_data_i,
  input  logic                            pop_i,
  output snoop_pkg::trace_word_t          head_o,
  output logic                            full_o,
  output logic                            empty_o,
  output logic [snoop_pkg::CNT_WIDTH-1:0] occupancy_o
);

  snoop_pkg::trace_word_t          mem [snoop_pkg::FIFO_DEPTH];
  logic [snoop_pkg::PTR_WIDTH-1:0] wr_ptr_q;
  logic [snoop_pkg::PTR_WIDTH-1:0] rd_ptr_q;
  logic [snoop_pkg::CNT_WIDTH-1:0] count_q;

  assign head_o      = mem[rd_ptr_q];
  assign occupancy_o = count_q;
  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == snoop_pkg::CNT_WIDTH'(snoop_pkg::FIFO_DEPTH));

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ------------------------------
  // Guards live in the snooper
  // ------------------------------
  a_no_push_full : assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o)
    else $error("trace_fifo: push while full");

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o)
    else $error("trace_fifo: pop while empty");

endmodule

// File: verilog/trace_snooper.sv
module trace_snooper (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  snoop_pkg::trace_word_t [snoop_pkg::NUM_CORES-1:0] lane_rec_i,
  input  logic [snoop_pkg::NUM_CORES-1:0]      lane_valid_i,
  input  logic [snoop_pkg::NUM_CORES-1:0][snoop_pkg::LANE_CNT_WIDTH-1:0] lane_count_i,
  input  snoop_pkg::snoop_cfg_t                cfg_i,
  input  logic                                 pop_i,
  input  logic [1:0]                           clear_i,
  output snoop_pkg::trace_word_t               head_o,
  output snoop_pkg::snoop_status_t             status_o,
  output logic                                 watermark_irq_o,
  output logic                                 trigger_irq_o
);

  snoop_pkg::trace_word_t          sel_rec;
  logic                            sel_valid;
  logic                            push;
  logic                            fifo_pop;
  logic                            full;
  logic                            empty;
  logic                            trig_hit;
  logic [snoop_pkg::CNT_WIDTH-1:0] occupancy;
  logic                            overflow_q;
  logic                            trigger_q;

  // ------------------------------
  // Lane select and push
  // ------------------------------
  assign sel_rec   = lane_rec_i[cfg_i.core_select];
  assign sel_valid = cfg_i.enable && lane_valid_i[cfg_i.core_select];
  assign push      = sel_valid && !full;
  assign fifo_pop  = pop_i && !empty;

  // Trigger address uses the packed high/low layout
  assign trig_hit = push && ({sel_rec.pc_dst_h, sel_rec.pc_dst_l} == cfg_i.trig_addr);

  trace_fifo i_fifo (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .push_i      ( push      ),
    .push_data_i ( sel_rec   ),
    .pop_i       ( fifo_pop  ),
    .head_o      ( head_o    ),
    .full_o      ( full      ),
    .empty_o     ( empty     ),
    .occupancy_o ( occupancy )
  );

  // Sticky flags, a new event wins over a clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      overflow_q      <= 1'b0;
      trigger_q       <= 1'b0;
      watermark_irq_o <= 1'b0;
    end else begin
      if (sel_valid && full) begin
        overflow_q <= 1'b1;
      end else if (clear_i[0]) begin
        overflow_q <= 1'b0;
      end
      if (trig_hit) begin
        trigger_q <= 1'b1;
      end else if (clear_i[1]) begin
        trigger_q <= 1'b0;
      end
      // Watermark of zero disables the interrupt
      watermark_irq_o <= (cfg_i.watermark != '0) && (occupancy >= cfg_i.watermark);
    end
  end

  assign trigger_irq_o = trigger_q;

  assign status_o = '{
    occupancy:  occupancy,
    overflow:   overflow_q,
    trigger:    trigger_q,
    lane_count: lane_count_i
  };

endmodule

// File: verilog/snoop_cfg_regs.sv
module snoop_cfg_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  snoop_pkg::lite_req_t     lite_req_i,
  output snoop_pkg::lite_rsp_t     lite_rsp_o,
  input  snoop_pkg::snoop_status_t status_i,
  input  snoop_pkg::trace_word_t   head_i,
  output snoop_pkg::snoop_cfg_t    cfg_o,
  output logic                     pop_o,
  output logic [1:0]               clear_o
);

  logic        wr_take;
  logic        rd_take;
  logic        wm_level;
  logic        rd_hit;
  logic [31:0] rd_data;
  logic [1:0]  ctrl_q;
  logic [3:0]  priv_mask_q;
  logic [3:0]  watermark_q;
  logic [31:0] trig_lo_q;
  logic [31:0] trig_hi_q;
  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;

  function automatic logic in_map(input logic [31:0] addr);
    return (addr <= snoop_pkg::REG_POP) && (addr[1:0] == 2'b00);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // Handshakes
  // ------------------------------
  // One write in flight with address and data taken together
  assign wr_take = lite_req_i.awvalid && lite_req_i.wvalid && !bvalid_q;
  assign rd_take = lite_req_i.arvalid && !rvalid_q;

  assign pop_o   = wr_take && (lite_req_i.awaddr == snoop_pkg::REG_POP);
  assign clear_o = (wr_take && (lite_req_i.awaddr == snoop_pkg::REG_STATUS) &&
                    lite_req_i.wstrb[1]) ? lite_req_i.wdata[9:8] : 2'b00;

  assign wm_level = (watermark_q != '0) && (status_i.occupancy >= watermark_q);

  // Configuration registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q      <= '0;
      priv_mask_q <= '0;
      watermark_q <= '0;
      trig_lo_q   <= '0;
      trig_hi_q   <= '0;
    end else if (wr_take) begin
      case (lite_req_i.awaddr)
        snoop_pkg::REG_CTRL: begin
          if (lite_req_i.wstrb[0]) ctrl_q <= lite_req_i.wdata[1:0];
        end
        snoop_pkg::REG_PRIV_MASK: begin
          if (lite_req_i.wstrb[0]) priv_mask_q <= lite_req_i.wdata[3:0];
        end
        snoop_pkg::REG_WATERMARK: begin
          if (lite_req_i.wstrb[0]) watermark_q <= lite_req_i.wdata[3:0];
        end
        snoop_pkg::REG_TRIG_LO: begin
          trig_lo_q <= merge_bytes(trig_lo_q, lite_req_i.wdata, lite_req_i.wstrb);
        end
        snoop_pkg::REG_TRIG_HI: begin
          trig_hi_q <= merge_bytes(trig_hi_q, lite_req_i.wdata, lite_req_i.wstrb);
        end
        default: ;
      endcase
    end
  end

  // ------------------------------
  // Read decode
  // ------------------------------
  always_comb begin
    rd_data = '0;
    rd_hit  = 1'b1;
    case (lite_req_i.araddr)
      snoop_pkg::REG_CTRL:      rd_data = {30'b0, ctrl_q};
      snoop_pkg::REG_PRIV_MASK: rd_data = {28'b0, priv_mask_q};
      snoop_pkg::REG_WATERMARK: rd_data = {28'b0, watermark_q};
      snoop_pkg::REG_TRIG_LO:   rd_data = trig_lo_q;
      snoop_pkg::REG_TRIG_HI:   rd_data = trig_hi_q;
      snoop_pkg::REG_STATUS: begin
        rd_data = {21'b0, wm_level, status_i.trigger, status_i.overflow, 4'b0,
                   status_i.occupancy};
      end
      snoop_pkg::REG_LANE0_CNT:         rd_data = {16'b0, status_i.lane_count[0]};
      snoop_pkg::REG_LANE1_CNT:         rd_data = {16'b0, status_i.lane_count[1]};
      snoop_pkg::REG_HEAD_BASE:         rd_data = head_i.pc_src_h;
      snoop_pkg::REG_HEAD_BASE + 32'h4: rd_data = head_i.pc_src_l;
      snoop_pkg::REG_HEAD_BASE + 32'h8: rd_data = head_i.pc_dst_h;
      snoop_pkg::REG_HEAD_BASE + 32'hC: rd_data = head_i.pc_dst_l;
      snoop_pkg::REG_HEAD_BASE + 32'h10: rd_data = head_i.metadata;
      snoop_pkg::REG_HEAD_BASE + 32'h14: rd_data = head_i.opcode;
      snoop_pkg::REG_HEAD_BASE + 32'h18: rd_data = head_i.priv_lvl;
      // Pop is write-only and reads zero
      snoop_pkg::REG_POP:       rd_data = '0;
      default:                  rd_hit = 1'b0;
    endcase
  end

  // Response channels hold until accepted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_take) begin
        bvalid_q <= 1'b1;
      end else if (lite_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_take) begin
        rvalid_q <= 1'b1;
      end else if (lite_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      bresp_q <= in_map(lite_req_i.awaddr) ? snoop_pkg::RESP_OKAY : snoop_pkg::RESP_DECERR;
    end
    if (rd_take) begin
      rdata_q <= rd_data;
      rresp_q <= rd_hit ? snoop_pkg::RESP_OKAY : snoop_pkg::RESP_DECERR;
    end
  end

  assign lite_rsp_o = '{
    awready: wr_take,
    wready:  wr_take,
    bvalid:  bvalid_q,
    bresp:   bresp_q,
    arready: rd_take,
    rvalid:  rvalid_q,
    rdata:   rdata_q,
    rresp:   rresp_q
  };

  assign cfg_o = '{
    enable:      ctrl_q[0],
    core_select: ctrl_q[1],
    priv_mask:   priv_mask_q,
    watermark:   watermark_q,
    trig_addr:   {trig_hi_q, trig_lo_q}
  };

  // ------------------------------
  // Bus checks
  // ------------------------------
  a_rsp_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    (bvalid_q && !lite_req_i.bready |=> bvalid_q && $stable(bresp_q)) and
    (rvalid_q && !lite_req_i.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q)))
    else $error("snoop_cfg_regs: response changed before handshake");

  // Read decode must cover every offset of the map
  a_no_decerr_in_map : assert property (@(posedge clk_i) disable iff (reset_i)
    rd_take && in_map(lite_req_i.araddr) |=> rresp_q != snoop_pkg::RESP_DECERR)
    else $error("snoop_cfg_regs: DECERR inside register map");

endmodule

// File: verilog/snoop_top.sv
module snoop_top (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  snoop_pkg::core_trace_t [snoop_pkg::NUM_CORES-1:0] trace_i,
  input  snoop_pkg::lite_req_t                              lite_req_i,
  output snoop_pkg::lite_rsp_t                              lite_rsp_o,
  output logic                                              watermark_irq_o,
  output logic                                              trigger_irq_o
);

  snoop_pkg::snoop_cfg_t                    cfg;
  snoop_pkg::snoop_status_t                 status;
  snoop_pkg::trace_word_t                   head;
  logic                                     pop;
  logic [1:0]                               clear;
  snoop_pkg::trace_word_t [snoop_pkg::NUM_CORES-1:0] lane_rec;
  logic [snoop_pkg::NUM_CORES-1:0]          lane_valid;
  logic [snoop_pkg::NUM_CORES-1:0][snoop_pkg::LANE_CNT_WIDTH-1:0] lane_count;

  // One lane per core
  for (genvar i = 0; i < snoop_pkg::NUM_CORES; i++) begin : gen_lane
    trace_lane i_lane (
      .clk_i       ( clk_i         ),
      .reset_i     ( reset_i       ),
      .trace_i     ( trace_i[i]    ),
      .priv_mask_i ( cfg.priv_mask ),
      .rec_o       ( lane_rec[i]   ),
      .rec_valid_o ( lane_valid[i] ),
      .count_o     ( lane_count[i] )
    );
  end

  trace_snooper i_snooper (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .lane_rec_i      ( lane_rec        ),
    .lane_valid_i    ( lane_valid      ),
    .lane_count_i    ( lane_count      ),
    .cfg_i           ( cfg             ),
    .pop_i           ( pop             ),
    .clear_i         ( clear           ),
    .head_o          ( head            ),
    .status_o        ( status          ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   )
  );

  snoop_cfg_regs i_regs (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .lite_req_i ( lite_req_i ),
    .lite_rsp_o ( lite_rsp_o ),
    .status_i   ( status     ),
    .head_i     ( head       ),
    .cfg_o      ( cfg        ),
    .pop_o      ( pop        ),
    .clear_o    ( clear      )
  );

endmodule

// File: tests/tb_snoop_top.sv
module tb_snoop_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TABLE_LEN   = 10;
  localparam int          CYCLE_LIMIT = 40 * TABLE_LEN + 2000;
  localparam int          SEL_CORE    = 1;
  localparam int          BURST_CORE  = 0;
  localparam int          WMARK       = 3;
  localparam logic [15:0] LFSR_SEED   = 16'd46;

  typedef struct packed {
    logic       core;
    logic [1:0] priv;
    logic [3:0] ctr;
    logic       keep;
  } entry_t;

  logic                                              clk_i;
  logic                                              reset_i;
  snoop_pkg::core_trace_t [snoop_pkg::NUM_CORES-1:0] trace;
  snoop_pkg::lite_req_t                              lite_req;
  snoop_pkg::lite_rsp_t                              lite_rsp;
  logic                                              watermark_irq;
  logic                                              trigger_irq;
  logic [15:0]                                       lfsr_q = LFSR_SEED;
  int                                                cycles = 0;

  // Privilege mask is 0xB, so level 2 is filtered out
  entry_t stim [TABLE_LEN] = '{
    '{1'b1, 2'd0, 4'h1, 1'b1}, '{1'b0, 2'd1, 4'h2, 1'b1},
    '{1'b1, 2'd2, 4'h3, 1'b0}, '{1'b1, 2'd3, 4'h4, 1'b1},
    '{1'b0, 2'd2, 4'h5, 1'b0}, '{1'b1, 2'd1, 4'h6, 1'b1},
    '{1'b0, 2'd0, 4'h7, 1'b1}, '{1'b1, 2'd0, 4'h8, 1'b1},
    '{1'b1, 2'd2, 4'h9, 1'b0}, '{1'b1, 2'd3, 4'hA, 1'b1}
  };

  snoop_top uut (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .trace_i         ( trace         ),
    .lite_req_i      ( lite_req      ),
    .lite_rsp_o      ( lite_rsp      ),
    .watermark_irq_o ( watermark_irq ),
    .trigger_irq_o   ( trigger_irq   )
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val = {val[62:0], lfsr_q[0]};
    end
  endtask

  task automatic make_trace(input logic [1:0] priv, input logic [3:0] ctr,
                            output snoop_pkg::core_trace_t t);
    logic [63:0] bits;
    t.v        = 1'b1;
    t.priv     = priv;
    t.ctr_type = ctr;
    take_bits(64, bits);
    t.src_pc = bits;
    take_bits(64, bits);
    t.dst_pc = bits;
    take_bits(32, bits);
    t.instr = bits[31:0];
  endtask

  // High word masks bit 63 and low word clears bit 0
  function automatic snoop_pkg::trace_word_t expect_rec(input snoop_pkg::core_trace_t t);
    snoop_pkg::trace_word_t r;
    r.pc_src_h = t.src_pc[63:32] & 32'h7FFF_FFFF;
    r.pc_src_l = t.src_pc[31:0] & 32'hFFFF_FFFE;
    r.pc_dst_h = t.dst_pc[63:32] & 32'h7FFF_FFFF;
    r.pc_dst_l = t.dst_pc[31:0] & 32'hFFFF_FFFE;
    r.metadata = 32'(t.ctr_type);
    r.opcode   = t.instr;
    r.priv_lvl = 32'(t.priv);
    return r;
  endfunction

  function automatic logic [31:0] status_word(input int occ, input logic ovf, input logic trg);
    logic level;
    level = (WMARK != 0) && (occ >= WMARK);
    return {21'b0, level, trg, ovf, 4'b0, occ[3:0]};
  endfunction

  task automatic drive_trace(input int core, input snoop_pkg::core_trace_t t);
    trace       = '0;
    trace[core] = t;
    @(posedge clk_i);
    #2;
    trace = '0;
  endtask

  // ------------------------------
  // AXI-Lite master
  // ------------------------------
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    lite_req.awvalid = 1'b1;
    lite_req.awaddr  = addr;
    lite_req.wvalid  = 1'b1;
    lite_req.wdata   = data;
    lite_req.wstrb   = 4'hF;
    do @(posedge clk_i); while (!(lite_rsp.awready && lite_rsp.wready));
    #2;
    lite_req.awvalid = 1'b0;
    lite_req.wvalid  = 1'b0;
    lite_req.bready  = 1'b1;
    do @(posedge clk_i); while (!lite_rsp.bvalid);
    resp = lite_rsp.bresp;
    #2;
    lite_req.bready = 1'b0;
    check("bresp", resp, snoop_pkg::RESP_OKAY);
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    lite_req.arvalid = 1'b1;
    lite_req.araddr  = addr;
    do @(posedge clk_i); while (!lite_rsp.arready);
    #2;
    lite_req.arvalid = 1'b0;
    lite_req.rready  = 1'b1;
    do @(posedge clk_i); while (!lite_rsp.rvalid);
    data = lite_rsp.rdata;
    resp = lite_rsp.rresp;
    #2;
    lite_req.rready = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, data, resp);
    check({name, " rresp"}, resp, snoop_pkg::RESP_OKAY);
    check(name, data, exp);
  endtask

  initial begin
    snoop_pkg::trace_word_t rec;
    snoop_pkg::trace_word_t exp_q [$];
    snoop_pkg::core_trace_t t;
    snoop_pkg::core_trace_t burst [9];
    logic [31:0]            data;
    logic [1:0]             resp;
    logic [63:0]            trig_pc;
    int                     lane_cnt [2];
    int                     occ;

    clk_i       = 1'b0;
    reset_i     = 1'b1;
    trace       = '0;
    lite_req    = '0;
    lane_cnt    = '{0, 0};
    repeat (16) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    // Register readback with a trigger low word that never matches since bit 0 is set
    write_reg(snoop_pkg::REG_PRIV_MASK, 32'hB);
    write_reg(snoop_pkg::REG_WATERMARK, 32'(WMARK));
    write_reg(snoop_pkg::REG_TRIG_LO, 32'h1234_5679);
    write_reg(snoop_pkg::REG_TRIG_HI, 32'h8765_4321);
    write_reg(snoop_pkg::REG_CTRL, 32'h3);
    read_expect("CTRL", snoop_pkg::REG_CTRL, 32'h3);
    read_expect("PRIV_MASK", snoop_pkg::REG_PRIV_MASK, 32'hB);
    read_expect("WATERMARK", snoop_pkg::REG_WATERMARK, 32'(WMARK));
    read_expect("TRIG_LO", snoop_pkg::REG_TRIG_LO, 32'h1234_5679);
    read_expect("TRIG_HI", snoop_pkg::REG_TRIG_HI, 32'h8765_4321);
    read_reg(32'h40, data, resp);
    check("rresp at 0x40", resp, snoop_pkg::RESP_DECERR);
    check("rdata at 0x40", data, 32'h0);

    // Table of traces with core 1 selected
    for (int i = 0; i < TABLE_LEN; i++) begin
      make_trace(stim[i].priv, stim[i].ctr, t);
      if (stim[i].keep) begin
        lane_cnt[stim[i].core]++;
        if (stim[i].core == SEL_CORE) begin
          exp_q.push_back(expect_rec(t));
        end
      end
      drive_trace(stim[i].core, t);
    end
    repeat (4) @(posedge clk_i);
    #2;
    read_expect("LANE0_CNT", snoop_pkg::REG_LANE0_CNT, lane_cnt[0]);
    read_expect("LANE1_CNT", snoop_pkg::REG_LANE1_CNT, lane_cnt[1]);
    occ = exp_q.size();
    read_expect("STATUS", snoop_pkg::REG_STATUS, status_word(occ, 1'b0, 1'b0));
    check("watermark_irq_o", watermark_irq, occ >= WMARK);

    // ------------------------------
    // Drain in order
    // ------------------------------
    while (exp_q.size() > 0) begin
      rec = exp_q.pop_front();
      for (int w = 0; w < 7; w++) begin
        read_expect($sformatf("head word %0d", w), snoop_pkg::REG_HEAD_BASE + 32'(4 * w),
                    rec[(6 - w) * 32 +: 32]);
      end
      write_reg(snoop_pkg::REG_POP, 32'h0);
      occ--;
      read_expect("STATUS", snoop_pkg::REG_STATUS, status_word(occ, 1'b0, 1'b0));
      check("watermark_irq_o", watermark_irq, occ >= WMARK);
    end

    // Nine core 0 records into an empty FIFO where the third hits the trigger
    for (int i = 0; i < 9; i++) begin
      make_trace(2'd0, 4'(i), burst[i]);
    end
    rec     = expect_rec(burst[2]);
    trig_pc = {rec.pc_dst_h, rec.pc_dst_l};
    write_reg(snoop_pkg::REG_TRIG_LO, trig_pc[31:0]);
    write_reg(snoop_pkg::REG_TRIG_HI, trig_pc[63:32]);
    write_reg(snoop_pkg::REG_CTRL, 32'h1);
    for (int i = 0; i < 9; i++) begin
      drive_trace(BURST_CORE, burst[i]);
    end
    lane_cnt[BURST_CORE] += 9;
    repeat (4) @(posedge clk_i);
    #2;
    read_expect("STATUS", snoop_pkg::REG_STATUS, status_word(8, 1'b1, 1'b1));
    check("trigger_irq_o", trigger_irq, 1'b1);
    read_expect("LANE0_CNT", snoop_pkg::REG_LANE0_CNT, lane_cnt[0]);
    read_expect("LANE1_CNT", snoop_pkg::REG_LANE1_CNT, lane_cnt[1]);
    write_reg(snoop_pkg::REG_STATUS, 32'h300);
    read_expect("STATUS", snoop_pkg::REG_STATUS, status_word(8, 1'b0, 1'b0));
    check("trigger_irq_o", trigger_irq, 1'b0);
    check("watermark_irq_o", watermark_irq, 1'b1);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: build.f
verilog/snoop_pkg.sv
verilog/trace_lane.sv
verilog/trace_fifo.sv
verilog/trace_snooper.sv
verilog/snoop_cfg_regs.sv
verilog/snoop_top.sv
tests/tb_snoop_top.sv
